/* hdl/ic_bus_pkg.sv */
// Bus widths of the CPU data port and of every target channel.
// OUTSTANDING_DEPTH must stay a power of two so the FIFO pointers wrap
// on their own. CNT_W must be able to hold OUTSTANDING_DEPTH itself.
package ic_bus_pkg;

    // ------------------------------------------------------------------------
    // Widths
    // ------------------------------------------------------------------------
    localparam int ADDR_W = 32;                // Byte address
    localparam int DATA_W = 32;                // One bus word
    localparam int STRB_W = DATA_W / 8;        // One strobe per byte

    // ------------------------------------------------------------------------
    // Outstanding requests
    // ------------------------------------------------------------------------
    localparam int OUTSTANDING_DEPTH = 4;      // Granted, not yet answered
    localparam int CNT_W = 3;                  // Counts 0..OUTSTANDING_DEPTH
    localparam int PTR_W = 2;                  // log2 of FIFO depth

    typedef logic [ADDR_W-1:0] addr_t;
    typedef logic [DATA_W-1:0] data_t;
    typedef logic [STRB_W-1:0] strb_t;

endpackage

/* hdl/ic_dmem_top.sv */
// Data-side interconnect of the CPU: one request port to ROM, RAM and an
// internal error responder. Responses come back in grant order, with up
// to OUTSTANDING_DEPTH requests in flight. ROM and RAM must answer their
// own requests in order and must hold each response until ack.
module ic_dmem_top
    import ic_bus_pkg::*, ic_map_pkg::*;
(
    input  logic  g_clk,
    input  logic  i_arst_n,

    input  logic  i_cpu_req,            // CPU request port
    input  logic  i_cpu_wen,
    input  strb_t i_cpu_strb,
    input  data_t i_cpu_wdata,
    input  addr_t i_cpu_addr,
    output logic  o_cpu_gnt,
    output logic  o_cpu_recv,
    input  logic  i_cpu_ack,
    output logic  o_cpu_error,
    output data_t o_cpu_rdata,

    output logic  o_rom_req,            // ROM channel
    output logic  o_rom_wen,
    output strb_t o_rom_strb,
    output data_t o_rom_wdata,
    output addr_t o_rom_addr,
    input  logic  i_rom_gnt,
    input  logic  i_rom_recv,
    output logic  o_rom_ack,
    input  logic  i_rom_error,
    input  data_t i_rom_rdata,

    output logic  o_ram_req,            // RAM channel
    output logic  o_ram_wen,
    output strb_t o_ram_strb,
    output data_t o_ram_wdata,
    output addr_t o_ram_addr,
    input  logic  i_ram_gnt,
    input  logic  i_ram_recv,
    output logic  o_ram_ack,
    input  logic  i_ram_error,
    input  data_t i_ram_rdata
);

    logic ctr_full;
    logic ctr_empty;
    logic tag_push;
    logic tag_pop;
    tgt_t push_tgt;
    tgt_t head_tgt;

    ic_mem_if rom_ch ();
    ic_mem_if ram_ch ();
    ic_mem_if err_ch ();

    // ------------------------------------------------------------------------
    // Channels to the pins
    // ------------------------------------------------------------------------
    assign o_rom_req    = rom_ch.req;
    assign o_rom_wen    = rom_ch.wen;
    assign o_rom_strb   = rom_ch.strb;
    assign o_rom_wdata  = rom_ch.wdata;
    assign o_rom_addr   = rom_ch.addr;
    assign o_rom_ack    = rom_ch.ack;
    assign rom_ch.gnt   = i_rom_gnt;
    assign rom_ch.recv  = i_rom_recv;
    assign rom_ch.error = i_rom_error;
    assign rom_ch.rdata = i_rom_rdata;

    assign o_ram_req    = ram_ch.req;
    assign o_ram_wen    = ram_ch.wen;
    assign o_ram_strb   = ram_ch.strb;
    assign o_ram_wdata  = ram_ch.wdata;
    assign o_ram_addr   = ram_ch.addr;
    assign o_ram_ack    = ram_ch.ack;
    assign ram_ch.gnt   = i_ram_gnt;
    assign ram_ch.recv  = i_ram_recv;
    assign ram_ch.error = i_ram_error;
    assign ram_ch.rdata = i_ram_rdata;

    // ------------------------------------------------------------------------
    // Request path
    // ------------------------------------------------------------------------
    ic_req_router u_req_router (
        .i_req      (i_cpu_req),
        .i_wen      (i_cpu_wen),
        .i_strb     (i_cpu_strb),
        .i_wdata    (i_cpu_wdata),
        .i_addr     (i_cpu_addr),
        .i_full     (ctr_full),
        .o_gnt      (o_cpu_gnt),
        .o_push     (tag_push),
        .o_push_tgt (push_tgt),
        .rom_ch     (rom_ch),
        .ram_ch     (ram_ch),
        .err_ch     (err_ch)
    );

    ic_err_responder u_err_responder (
        .g_clk    (g_clk),
        .i_arst_n (i_arst_n),
        .err_ch   (err_ch)
    );

    // ------------------------------------------------------------------------
    // Ordering and response path
    // ------------------------------------------------------------------------
    ic_outstanding_ctr u_outstanding_ctr (
        .g_clk    (g_clk),
        .i_arst_n (i_arst_n),
        .i_push   (tag_push),
        .i_pop    (tag_pop),
        .o_full   (ctr_full),
        .o_empty  (ctr_empty)
    );

    ic_route_fifo u_route_fifo (
        .g_clk      (g_clk),
        .i_arst_n   (i_arst_n),
        .i_push     (tag_push),
        .i_push_tgt (push_tgt),
        .i_pop      (tag_pop),
        .o_head_tgt (head_tgt)
    );

    ic_rsp_mux u_rsp_mux (
        .i_head_tgt  (head_tgt),
        .i_empty     (ctr_empty),
        .rom_ch      (rom_ch),
        .ram_ch      (ram_ch),
        .err_ch      (err_ch),
        .i_cpu_ack   (i_cpu_ack),
        .o_cpu_recv  (o_cpu_recv),
        .o_cpu_error (o_cpu_error),
        .o_cpu_rdata (o_cpu_rdata),
        .o_pop       (tag_pop)
    );

endmodule

/* hdl/ic_err_responder.sv */
// Answers every unmapped request with an error and zero read data.
// Only one request is served at a time. A new request waits for gnt
// until the previous error response has been acked.
module ic_err_responder (
    input  logic g_clk,
    input  logic i_arst_n,
    ic_mem_if.target err_ch
);

    // Low is IDLE, high is RESPOND
    logic respond_q;

    always_ff @(posedge g_clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            respond_q <= 1'b0;
        end else begin
            case (respond_q)
                1'b0: begin                     // IDLE
                    if (err_ch.req) begin
                        respond_q <= 1'b1;      // Granted this cycle
                    end
                end
                default: begin                  // RESPOND
                    if (err_ch.ack) begin
                        respond_q <= 1'b0;
                    end
                end
            endcase
        end
    end

    assign err_ch.gnt   = err_ch.req && !respond_q;    // Same cycle when idle
    assign err_ch.recv  = respond_q;                   // Cycle after grant
    assign err_ch.error = respond_q;
    assign err_ch.rdata = '0;

    // Ack only arrives while an error response is offered
    a_ack_with_recv: assert property (@(posedge g_clk) disable iff (!i_arst_n)
        err_ch.ack |-> err_ch.recv);

endmodule

/* hdl/ic_map_pkg.sv */
// Memory map of the data-side interconnect.
// Each window is a power-of-two block aligned to its size, so a plain
// region compare on the upper address bits is a full decode.
// Anything outside both windows goes to the error responder.
package ic_map_pkg;
    import ic_bus_pkg::*;

    // ------------------------------------------------------------------------
    // Windows
    // ------------------------------------------------------------------------
    localparam addr_t MAP_ROM_MATCH = 32'h1000_0000;  // 16 KiB ROM
    localparam addr_t MAP_ROM_MASK  = 32'hFFFF_C000;
    localparam addr_t MAP_RAM_MATCH = 32'h2000_0000;  // 64 KiB RAM
    localparam addr_t MAP_RAM_MASK  = 32'hFFFF_0000;

    localparam int ROM_REGION_W = 18;                 // Ones in MAP_ROM_MASK
    localparam int ROM_OFFSET_W = ADDR_W - ROM_REGION_W;
    localparam int RAM_REGION_W = 16;                 // Ones in MAP_RAM_MASK
    localparam int RAM_OFFSET_W = ADDR_W - RAM_REGION_W;

    // Route tag kept per granted request
    typedef enum logic [1:0] {
        TGT_ROM = 2'd0,
        TGT_RAM = 2'd1,
        TGT_ERR = 2'd2
    } tgt_t;

    // One address word, split per window
    typedef union packed {
        struct packed {
            logic [ROM_REGION_W-1:0] region;          // Compared to ROM match
            logic [ROM_OFFSET_W-1:0] offset;          // Byte within ROM
        } rom_view;
        struct packed {
            logic [RAM_REGION_W-1:0] region;          // Compared to RAM match
            logic [RAM_OFFSET_W-1:0] offset;          // Byte within RAM
        } ram_view;
    } map_addr_u;

endpackage

/* hdl/ic_mem_if.sv */
// One target-side channel with the req/gnt request and recv/ack response
// handshakes. Request fields are held stable from req until gnt, response
// fields are held stable from recv until ack.
interface ic_mem_if
    import ic_bus_pkg::*;
();

    logic  req;        // Request pending
    logic  gnt;        // Request accepted this cycle
    logic  wen;        // Write when high, read when low
    strb_t strb;       // Byte enables of a write
    data_t wdata;      // Write data
    addr_t addr;       // Byte address

    logic  recv;       // Response pending
    logic  ack;        // Response taken this cycle
    logic  error;      // Response is an error
    data_t rdata;      // Read data

    // Interconnect side of the channel
    modport initiator (
        output req, wen, strb, wdata, addr, ack,
        input  gnt, recv, error, rdata
    );

    // Memory or responder side of the channel
    modport target (
        input  req, wen, strb, wdata, addr, ack,
        output gnt, recv, error, rdata
    );

endinterface

/* hdl/ic_outstanding_ctr.sv */
// Counts requests granted to the CPU and not yet answered.
// The router and the response mux must gate push and pop with full and
// empty. The counter itself does not saturate.
module ic_outstanding_ctr
    import ic_bus_pkg::*;
(
    input  logic g_clk,
    input  logic i_arst_n,
    input  logic i_push,                // CPU request transfer
    input  logic i_pop,                 // CPU response transfer
    output logic o_full,
    output logic o_empty
);

    logic [CNT_W-1:0] cnt_q;            // Requests in flight

    always_ff @(posedge g_clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            cnt_q <= '0;
        end else begin
            case ({i_push, i_pop})
                2'b10:   cnt_q <= cnt_q + 1'b1;
                2'b01:   cnt_q <= cnt_q - 1'b1;
                default: cnt_q <= cnt_q;    // Idle, or one in and one out
            endcase
        end
    end

    assign o_full  = (cnt_q == CNT_W'(OUTSTANDING_DEPTH));
    assign o_empty = (cnt_q == '0);

    // Router must stop granting at the limit
    a_no_push_full: assert property (@(posedge g_clk) disable iff (!i_arst_n)
        i_push |-> !o_full);

    // Response mux must not take a response nobody asked for
    a_no_pop_empty: assert property (@(posedge g_clk) disable iff (!i_arst_n)
        i_pop |-> !o_empty);

endmodule

/* hdl/ic_req_router.sv */
// Decodes the CPU address and steers the request to exactly one channel.
// The CPU grant is the chosen channel's gnt, the same cycle. Nothing is
// offered to a target while the outstanding counter is full.
module ic_req_router
    import ic_bus_pkg::*, ic_map_pkg::*;
(
    input  logic  i_req,
    input  logic  i_wen,
    input  strb_t i_strb,
    input  data_t i_wdata,
    input  addr_t i_addr,
    input  logic  i_full,               // No room for another tag
    output logic  o_gnt,
    output logic  o_push,               // One cycle per CPU transfer
    output tgt_t  o_push_tgt,
    ic_mem_if.initiator rom_ch,
    ic_mem_if.initiator ram_ch,
    ic_mem_if.initiator err_ch
);

    map_addr_u dec_addr;
    logic      rom_hit;
    logic      ram_hit;
    logic      req_ok;                  // Request allowed out this cycle
    logic      sel_gnt;                 // gnt of the decoded channel
    tgt_t      tgt;

    // ------------------------------------------------------------------------
    // Address decode
    // ------------------------------------------------------------------------
    assign dec_addr = i_addr;
    assign rom_hit  = (dec_addr.rom_view.region & MAP_ROM_MASK[ADDR_W-1 -: ROM_REGION_W])
                      == MAP_ROM_MATCH[ADDR_W-1 -: ROM_REGION_W];
    assign ram_hit  = (dec_addr.ram_view.region & MAP_RAM_MASK[ADDR_W-1 -: RAM_REGION_W])
                      == MAP_RAM_MATCH[ADDR_W-1 -: RAM_REGION_W];

    always_comb begin
        if (rom_hit) tgt = TGT_ROM;
        else if (ram_hit) tgt = TGT_RAM;
        else tgt = TGT_ERR;             // Unmapped
    end

    // ------------------------------------------------------------------------
    // Steering
    // ------------------------------------------------------------------------
    assign req_ok     = i_req && !i_full;
    assign rom_ch.req = req_ok && (tgt == TGT_ROM);
    assign ram_ch.req = req_ok && (tgt == TGT_RAM);
    assign err_ch.req = req_ok && (tgt == TGT_ERR);

    assign rom_ch.wen   = i_wen;        // Write fields fan out to all
    assign rom_ch.strb  = i_strb;
    assign rom_ch.wdata = i_wdata;
    assign rom_ch.addr  = i_addr;
    assign ram_ch.wen   = i_wen;
    assign ram_ch.strb  = i_strb;
    assign ram_ch.wdata = i_wdata;
    assign ram_ch.addr  = i_addr;
    assign err_ch.wen   = i_wen;
    assign err_ch.strb  = i_strb;
    assign err_ch.wdata = i_wdata;
    assign err_ch.addr  = i_addr;

    always_comb begin
        case (tgt)
            TGT_ROM: sel_gnt = rom_ch.gnt;
            TGT_RAM: sel_gnt = ram_ch.gnt;
            default: sel_gnt = err_ch.gnt;
        endcase
    end

    assign o_gnt      = req_ok && sel_gnt;  // Target gnt without req ignored
    assign o_push     = o_gnt;
    assign o_push_tgt = tgt;

endmodule

/* hdl/ic_route_fifo.sv */
// Keeps the route tag of every granted request in grant order.
// There is no fill level here. The outstanding counter owns full and
// empty, and the head entry is only meaningful while it reports non-empty.
module ic_route_fifo
    import ic_bus_pkg::*, ic_map_pkg::*;
(
    input  logic g_clk,
    input  logic i_arst_n,
    input  logic i_push,                // Write one tag
    input  tgt_t i_push_tgt,
    input  logic i_pop,                 // Drop the head tag
    output tgt_t o_head_tgt             // Target owing the next response
);

    tgt_t             tag_mem [OUTSTANDING_DEPTH];
    logic [PTR_W-1:0] wr_ptr_q;
    logic [PTR_W-1:0] rd_ptr_q;

    // ------------------------------------------------------------------------
    // Pointers
    // ------------------------------------------------------------------------
    always_ff @(posedge g_clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
        end else begin
            if (i_push) begin
                wr_ptr_q <= wr_ptr_q + 1'b1;    // Wraps at depth
            end
            if (i_pop) begin
                rd_ptr_q <= rd_ptr_q + 1'b1;
            end
        end
    end

    // ------------------------------------------------------------------------
    // Tag storage
    // ------------------------------------------------------------------------
    always_ff @(posedge g_clk) begin
        if (i_push) begin
            tag_mem[wr_ptr_q] <= i_push_tgt;
        end
    end

    assign o_head_tgt = tag_mem[rd_ptr_q];  // Read is combinational

endmodule

/* hdl/ic_rsp_mux.sv */
// Presents the response of the target at the FIFO head to the CPU.
// Responses from other targets wait at their own channel until their tag
// reaches the head. Nothing is presented while no request is in flight.
module ic_rsp_mux
    import ic_bus_pkg::*, ic_map_pkg::*;
(
    input  tgt_t  i_head_tgt,           // Oldest outstanding target
    input  logic  i_empty,              // No request in flight
    ic_mem_if.initiator rom_ch,
    ic_mem_if.initiator ram_ch,
    ic_mem_if.initiator err_ch,
    input  logic  i_cpu_ack,
    output logic  o_cpu_recv,
    output logic  o_cpu_error,
    output data_t o_cpu_rdata,
    output logic  o_pop                 // One cycle per response transfer
);

    always_comb begin
        o_cpu_recv  = 1'b0;
        o_cpu_error = 1'b0;
        o_cpu_rdata = '0;
        rom_ch.ack  = 1'b0;             // Non-head targets never see ack
        ram_ch.ack  = 1'b0;
        err_ch.ack  = 1'b0;
        if (!i_empty) begin
            case (i_head_tgt)
                TGT_ROM: begin
                    o_cpu_recv  = rom_ch.recv;
                    o_cpu_error = rom_ch.error;
                    o_cpu_rdata = rom_ch.rdata;
                    rom_ch.ack  = i_cpu_ack;
                end
                TGT_RAM: begin
                    o_cpu_recv  = ram_ch.recv;
                    o_cpu_error = ram_ch.error;
                    o_cpu_rdata = ram_ch.rdata;
                    ram_ch.ack  = i_cpu_ack;
                end
                default: begin          // TGT_ERR
                    o_cpu_recv  = err_ch.recv;
                    o_cpu_error = err_ch.error;
                    o_cpu_rdata = err_ch.rdata;
                    err_ch.ack  = i_cpu_ack;
                end
            endcase
        end
    end

    assign o_pop = o_cpu_recv && i_cpu_ack;

endmodule

/* sim/tb_clkgen.sv */
// Free-running 100 ns clock and an active-low reset.
// Reset is held for the first 10 rising edges and let go 10 ns after
// the last of them, in step with the stimulus drive time.
module tb_clkgen (
    output logic g_clk,
    output logic o_arst_n
);
    timeunit 1ns;
    timeprecision 1ps;

    localparam int RST_CYCLES = 10;

    initial begin
        g_clk = 1'b0;
        forever #50 g_clk = ~g_clk;         // 100 ns period
    end

    initial begin
        o_arst_n = 1'b0;
        repeat (RST_CYCLES) @(posedge g_clk);
        #10 o_arst_n = 1'b1;                // Released off the edge
    end

endmodule

/* sim/tb_ic_top.sv */
// Testbench of the data-side interconnect with ROM and RAM models.
// All DUT inputs change 10 ns after the rising edge, all outputs are
// sampled at the falling edge. RAM words never written read as the
// inverted word address. Targets answer 1 to 3 cycles after a grant.
module tb_ic_top
    import ic_bus_pkg::*, ic_map_pkg::*;
();
    timeunit 1ns;
    timeprecision 1ps;

    localparam data_t ROM_XOR = 32'hA5A5_0000;  // ROM read pattern
    localparam int    N_RAND  = 60;             // Random mix length
    localparam int    N_TXN   = 5 + 6 + 4 + 8 + N_RAND;

    logic  g_clk, i_arst_n;
    logic  i_cpu_req, i_cpu_wen, o_cpu_gnt, o_cpu_recv, i_cpu_ack, o_cpu_error;
    strb_t i_cpu_strb;
    data_t i_cpu_wdata, o_cpu_rdata;
    addr_t i_cpu_addr;
    logic  o_rom_req, o_rom_wen, i_rom_gnt, i_rom_recv, o_rom_ack, i_rom_error;
    strb_t o_rom_strb;
    data_t o_rom_wdata, i_rom_rdata;
    addr_t o_rom_addr;
    logic  o_ram_req, o_ram_wen, i_ram_gnt, i_ram_recv, o_ram_ack, i_ram_error;
    strb_t o_ram_strb;
    data_t o_ram_wdata, i_ram_rdata;
    addr_t o_ram_addr;

    logic [DATA_W:0] exp_q[$];                  // {error, rdata} per grant
    string           name_q[$];
    string           cur_test = "reset";
    data_t           ref_mem [logic [29:0]];    // Reference RAM contents
    data_t           ram_mem [logic [29:0]];    // RAM model contents
    data_t           rom_q[$], ram_q[$];        // Pending target responses
    int              rom_due[$], ram_due[$];    // Cycle each may be shown
    int              errors = 0;
    int              n_gnt = 0, n_rsp = 0, n_issued = 0;

    tb_clkgen u_clkgen (.g_clk(g_clk), .o_arst_n(i_arst_n));
    ic_dmem_top dut0 (.*);

    // ------------------------------------------------------------------------
    // Reference model
    // ------------------------------------------------------------------------
    function automatic tgt_t ref_target(addr_t a);
        if ((a & MAP_ROM_MASK) == MAP_ROM_MATCH) return TGT_ROM;
        if ((a & MAP_RAM_MASK) == MAP_RAM_MATCH) return TGT_RAM;
        return TGT_ERR;
    endfunction

    function automatic data_t fill_word(addr_t a);
        return ~{a[ADDR_W-1:2], 2'b00};         // Whole word address
    endfunction

    function automatic data_t merge_bytes(data_t old_w, data_t new_w, strb_t strb);
        data_t w;
        w = old_w;
        for (int b = 0; b < STRB_W; b++) begin
            if (strb[b]) w[8*b +: 8] = new_w[8*b +: 8];
        end
        return w;
    endfunction

    function automatic logic [DATA_W:0] expected_rsp(addr_t a, logic wen, strb_t strb,
                                                     data_t wd);
        data_t w;
        case (ref_target(a))
            TGT_ROM: return {1'b0, a ^ ROM_XOR};    // Writes ignored
            TGT_RAM: begin
                w = ref_mem.exists(a[31:2]) ? ref_mem[a[31:2]] : fill_word(a);
                if (wen) w = merge_bytes(w, wd, strb);
                ref_mem[a[31:2]] = w;
                return {1'b0, w};                   // Word after the access
            end
            default: return {1'b1, {DATA_W{1'b0}}};
        endcase
    endfunction

    // ------------------------------------------------------------------------
    // ROM and RAM models
    // ------------------------------------------------------------------------
    initial begin : target_models
        int    cyc, rom_wait, ram_wait;
        data_t w;
        cyc = 0;
        rom_wait = 0;
        ram_wait = 0;
        i_rom_gnt   = 1'b0;
        i_rom_recv  = 1'b0;
        i_rom_error = 1'b0;
        i_rom_rdata = '0;
        i_ram_gnt   = 1'b0;
        i_ram_recv  = 1'b0;
        i_ram_error = 1'b0;
        i_ram_rdata = '0;
        forever begin
            @(negedge g_clk);
            cyc++;
            if (o_rom_req && i_rom_gnt) begin           // ROM transfer
                rom_q.push_back(o_rom_addr ^ ROM_XOR);
                rom_due.push_back(cyc + $urandom_range(1, 3));
                rom_wait = $urandom_range(0, 2);
            end else if (rom_wait > 0) begin
                rom_wait--;
            end
            if (i_rom_recv && o_rom_ack) begin
                void'(rom_q.pop_front());
                void'(rom_due.pop_front());
            end
            if (o_ram_req && i_ram_gnt) begin           // RAM transfer
                w = ram_mem.exists(o_ram_addr[31:2]) ? ram_mem[o_ram_addr[31:2]]
                                                     : fill_word(o_ram_addr);
                if (o_ram_wen) w = merge_bytes(w, o_ram_wdata, o_ram_strb);
                ram_mem[o_ram_addr[31:2]] = w;
                ram_q.push_back(w);
                ram_due.push_back(cyc + $urandom_range(1, 3));
                ram_wait = $urandom_range(0, 2);
            end else if (ram_wait > 0) begin
                ram_wait--;
            end
            if (i_ram_recv && o_ram_ack) begin
                void'(ram_q.pop_front());
                void'(ram_due.pop_front());
            end
            @(posedge g_clk);
            #10;
            i_rom_gnt   = (rom_wait == 0);              // Ready ahead of req
            i_rom_recv  = (rom_q.size() > 0) && (cyc >= rom_due[0]);
            i_rom_rdata = i_rom_recv ? rom_q[0] : '0;
            i_ram_gnt   = (ram_wait == 0);
            i_ram_recv  = (ram_q.size() > 0) && (cyc >= ram_due[0]);
            i_ram_rdata = i_ram_recv ? ram_q[0] : '0;
        end
    end

    // CPU ack is held low 0 to 5 cycles per response
    initial begin : ack_driver
        int ack_wait;
        ack_wait = 0;
        i_cpu_ack = 1'b0;
        forever begin
            @(negedge g_clk);
            if (o_cpu_recv && i_cpu_ack) ack_wait = $urandom_range(0, 5);
            else if (o_cpu_recv && ack_wait > 0) ack_wait--;
            @(posedge g_clk);
            #10;
            i_cpu_ack = (ack_wait == 0);
        end
    end

    // ------------------------------------------------------------------------
    // Compare
    // ------------------------------------------------------------------------
    initial begin : compare
        logic            held, held_err;
        data_t           held_data;
        logic [DATA_W:0] exp_rsp;
        string           name;
        held = 1'b0;
        forever begin
            @(negedge g_clk);
            if (!i_arst_n) continue;
            assert ((!o_rom_req || (i_cpu_req && ref_target(i_cpu_addr) == TGT_ROM))
                    && (!o_ram_req || (i_cpu_req && ref_target(i_cpu_addr) == TGT_RAM)))
                else begin
                    errors++;
                    $display("[%s] request to %h reached the wrong target", cur_test,
                             i_cpu_addr);
                end
            assert (!o_rom_req || {o_rom_wen, o_rom_strb, o_rom_wdata, o_rom_addr}
                    == {i_cpu_wen, i_cpu_strb, i_cpu_wdata, i_cpu_addr})
                else begin
                    errors++;
                    $display("[%s] ROM request fields differ from the CPU request",
                             cur_test);
                end
            if (held) begin                             // Response must hold
                assert (o_cpu_recv && o_cpu_error == held_err && o_cpu_rdata == held_data)
                    else begin
                        errors++;
                        $display("[%s] CPU response changed before it was acked",
                                 cur_test);
                    end
            end
            held      = o_cpu_recv && !i_cpu_ack;
            held_err  = o_cpu_error;
            held_data = o_cpu_rdata;
            if (o_cpu_recv && i_cpu_ack) begin
                n_rsp++;
                assert (exp_q.size() > 0) else begin
                    errors++;
                    $display("CPU got a response with no request in flight");
                end
                if (exp_q.size() > 0) begin
                    exp_rsp = exp_q.pop_front();
                    name    = name_q.pop_front();
                    assert ({o_cpu_error, o_cpu_rdata} == exp_rsp) else begin
                        errors++;
                        $display("** Error %s: expected err=%b data=%h, actual err=%b data=%h",
                                 name, exp_rsp[DATA_W], exp_rsp[DATA_W-1:0],
                                 o_cpu_error, o_cpu_rdata);
                    end
                end
            end
            if (i_cpu_req && o_cpu_gnt) begin           // Grant order is answer order
                exp_q.push_back(expected_rsp(i_cpu_addr, i_cpu_wen, i_cpu_strb,
                                             i_cpu_wdata));
                name_q.push_back(cur_test);
                n_gnt++;
            end
            assert (n_gnt - n_rsp <= OUTSTANDING_DEPTH) else begin
                errors++;
                $display("[%s] more than %0d requests in flight", cur_test,
                         OUTSTANDING_DEPTH);
            end
        end
    end

    // ------------------------------------------------------------------------
    // Stimulus
    // ------------------------------------------------------------------------
    task automatic cpu_issue(addr_t addr, logic wen, strb_t strb, data_t wdata);
        i_cpu_req   = 1'b1;
        i_cpu_wen   = wen;
        i_cpu_strb  = strb;
        i_cpu_wdata = wdata;
        i_cpu_addr  = addr;
        do @(negedge g_clk); while (!o_cpu_gnt);
        @(posedge g_clk);
        #10;
        i_cpu_req = 1'b0;                           // Next call may raise it again
        n_issued++;
    endtask

    initial begin : stimulus
        addr_t a;
        logic  wen;
        void'($urandom(32'h5f0d));
        i_cpu_req   = 1'b0;
        i_cpu_wen   = 1'b0;
        i_cpu_strb  = '0;
        i_cpu_wdata = '0;
        i_cpu_addr  = '0;
        @(posedge i_arst_n);
        @(negedge g_clk);
        assert (!o_cpu_gnt && !o_cpu_recv && !o_rom_req && !o_ram_req
                && !o_rom_ack && !o_ram_ack) else begin
            errors++;
            $display("DUT outputs not idle after reset");
        end
        @(posedge g_clk);
        #10;
        cur_test = "ram_strobe";
        cpu_issue(32'h2000_0010, 1'b1, 4'b1111, 32'h1122_3344);
        cpu_issue(32'h2000_0010, 1'b1, 4'b0101, 32'hAABB_CCDD);
        cpu_issue(32'h2000_0010, 1'b0, 4'b0000, 32'h0);
        cpu_issue(32'h2000_0024, 1'b1, 4'b1000, 32'h7700_0000);
        cpu_issue(32'h2000_0024, 1'b0, 4'b0000, 32'h0);
        cur_test = "rom_read";
        for (int i = 0; i < 5; i++) cpu_issue(MAP_ROM_MATCH + i * 32'h404, 1'b0, '0, '0);
        cpu_issue(32'h1000_3FFC, 1'b0, '0, '0);     // Last ROM word
        cur_test = "unmapped";
        cpu_issue(32'h4000_0000, 1'b0, '0, '0);
        cpu_issue(32'h1000_4000, 1'b0, '0, '0);     // Just past ROM
        cpu_issue(32'h0000_0000, 1'b1, 4'hF, 32'h1234_5678);
        cpu_issue(32'h2001_0000, 1'b0, '0, '0);     // Just past RAM
        cur_test = "ack_hold";
        for (int i = 0; i < 8; i++) begin
            case (i % 3)
                0:       a = MAP_ROM_MATCH + i * 4;
                1:       a = 32'h2000_0010;
                default: a = 32'h5000_0000 + i * 4;
            endcase
            cpu_issue(a, 1'b0, '0, '0);
        end
        cur_test = "random_mix";
        for (int i = 0; i < N_RAND; i++) begin
            case ($urandom_range(0, 2))
                0:       a = MAP_ROM_MATCH | ($urandom & 32'h0000_3FFC);
                1:       a = MAP_RAM_MATCH | ($urandom & 32'h0000_00FC);  // Reuse words
                default: a = 32'h4000_0000 | ($urandom & 32'h0FFF_FFFC);
            endcase
            wen = ($urandom_range(0, 1) == 1);
            cpu_issue(a, wen, strb_t'($urandom), data_t'($urandom));
        end
        while (n_rsp < n_gnt) @(posedge g_clk);     // Drain in-flight responses
        assert (n_gnt == n_issued) else begin
            errors++;
            $display("grant count %0d does not match issued count %0d", n_gnt, n_issued);
        end
        $display("Checks done: %0d errors over %0d grants and %0d responses",
                 errors, n_gnt, n_rsp);
        if (errors == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

    initial begin : watchdog
        repeat (N_TXN * 20 + 200) @(posedge g_clk);
        $display("Run hung: not all %0d transactions finished within %0d cycles",
                 N_TXN, N_TXN * 20 + 200);
        $display("=== FAIL ===");
        $finish;
    end

endmodule

/* tb.f */
hdl/ic_bus_pkg.sv
hdl/ic_map_pkg.sv
hdl/ic_mem_if.sv
hdl/ic_req_router.sv
hdl/ic_outstanding_ctr.sv
hdl/ic_route_fifo.sv
hdl/ic_err_responder.sv
hdl/ic_rsp_mux.sv
hdl/ic_dmem_top.sv
sim/tb_clkgen.sv
sim/tb_ic_top.sv
